// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = vdec_tb
FILELIST  = files.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "NO ERRORS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: design/vdec_ctrl_if.sv
interface vdec_ctrl_if;
  logic legal;
  vdec_pkg::vreg_t vd;
  vdec_pkg::vreg_t vs1;
  vdec_pkg::vreg_t vs2;
  vdec_pkg::vs2_src_t vs2_src;
  vdec_pkg::vd_src_t vd_src;
  // vm set means unmasked
  logic vm;
  vdec_pkg::imm5_t imm5;
  vdec_pkg::xlen_t rs1_val;
  vdec_pkg::sew_t eew;

  modport dec (
    output legal, vd, vs1, vs2, vs2_src, vd_src, vm, imm5, rs1_val, eew
  );

  modport user (
    input legal, vd, vs1, vs2, vs2_src, vd_src, vm, imm5, rs1_val, eew
  );
endinterface

// File: design/vdec_elem_if.sv
interface vdec_elem_if;
  logic start;
  logic advance;
  // index of the lane 0 element
  vdec_pkg::offset_t offset;
  logic lane1_active;
  logic last;
  logic empty;

  modport seq (
    output start, advance,
    input offset, lane1_active, last, empty
  );

  modport cnt (
    input start, advance,
    output offset, lane1_active, last, empty
  );
endinterface

// File: design/vdec_element_counter.sv
module vdec_element_counter #(
  parameter int VLMAX = 32
) (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic [$clog2(VLMAX+1)-1:0]   vl,
  input  logic [$clog2(VLMAX+1)-1:0]   vstart,
  vdec_elem_if.cnt                     elem
);

  vdec_pkg::offset_t vl_q;
  vdec_pkg::offset_t vstart_q;
  vdec_pkg::offset_t idx;
  // one extra bit so the compares near the top do not wrap
  logic [vdec_pkg::OFFSET_W:0] idx_p1;
  logic [vdec_pkg::OFFSET_W:0] idx_p2;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      vl_q     <= '0;
      vstart_q <= '0;
      idx      <= '0;
    end else if (elem.start) begin
      vl_q     <= vdec_pkg::offset_t'(vl);
      vstart_q <= vdec_pkg::offset_t'(vstart);
      idx      <= vdec_pkg::offset_t'(vstart);
    end else if (elem.advance) begin
      idx <= idx + 8'd2;
    end
  end

  assign idx_p1 = {1'b0, idx} + 9'd1;
  assign idx_p2 = {1'b0, idx} + 9'd2;

  assign elem.offset       = idx;
  assign elem.lane1_active = idx_p1 < {1'b0, vl_q};
  assign elem.last         = idx_p2 >= {1'b0, vl_q};
  assign elem.empty        = vstart_q >= vl_q;

endmodule

// File: design/vdec_instr_decoder.sv
module vdec_instr_decoder (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             load,
  input  vdec_pkg::instr_t instr,
  input  vdec_pkg::xlen_t  xs1,
  input  vdec_pkg::sew_t   vtype_sew,
  vdec_ctrl_if.dec         ctrl
);

  vdec_pkg::funct6_t funct6;
  vdec_pkg::funct3_t funct3;
  logic legal_d;
  logic widen;
  logic narrow;
  vdec_pkg::vs2_src_t vs2_src_d;
  vdec_pkg::vd_src_t vd_src_d;
  vdec_pkg::sew_t eew_d;

  assign funct6 = instr[31:26];
  assign funct3 = instr[14:12];

  always_comb begin
    legal_d   = 1'b0;
    widen     = 1'b0;
    narrow    = 1'b0;
    vs2_src_d = vdec_pkg::VS2_NORMAL;
    vd_src_d  = vdec_pkg::VD_NORMAL;
    case (funct6)
      vdec_pkg::F6_VADD: begin
        legal_d = (funct3 == vdec_pkg::OPIVV) || (funct3 == vdec_pkg::OPIVX) ||
                  (funct3 == vdec_pkg::OPIVI);
      end
      // slideup moves the destination, slidedown moves the source
      vdec_pkg::F6_VSLIDEUP, vdec_pkg::F6_VSLIDEDOWN: begin
        legal_d = (funct3 == vdec_pkg::OPIVX) || (funct3 == vdec_pkg::OPIVI) ||
                  (funct3 == vdec_pkg::OPMVX);
        if (funct6 == vdec_pkg::F6_VSLIDEUP) begin
          vd_src_d = (funct3 == vdec_pkg::OPIVX) ? vdec_pkg::VD_IDX_PLUS_RS1 :
                     (funct3 == vdec_pkg::OPIVI) ? vdec_pkg::VD_IDX_PLUS_UIMM :
                                                   vdec_pkg::VD_IDX_PLUS_1;
        end else begin
          vs2_src_d = (funct3 == vdec_pkg::OPIVX) ? vdec_pkg::VS2_IDX_PLUS_RS1 :
                      (funct3 == vdec_pkg::OPIVI) ? vdec_pkg::VS2_IDX_PLUS_UIMM :
                                                    vdec_pkg::VS2_IDX_PLUS_1;
        end
      end
      vdec_pkg::F6_VRGATHER: begin
        legal_d   = (funct3 == vdec_pkg::OPIVX) || (funct3 == vdec_pkg::OPIVI);
        vs2_src_d = (funct3 == vdec_pkg::OPIVX) ? vdec_pkg::VS2_RS1 : vdec_pkg::VS2_UIMM;
      end
      vdec_pkg::F6_VWADDU: begin
        legal_d = (funct3 == vdec_pkg::OPMVV);
        widen   = 1'b1;
      end
      vdec_pkg::F6_VNSRL: begin
        legal_d = (funct3 == vdec_pkg::OPIVV);
        narrow  = 1'b1;
      end
      default: begin
        legal_d = 1'b0;
      end
    endcase
  end

  // destination width after widening or narrowing
  always_comb begin
    eew_d = vtype_sew;
    if (widen) begin
      eew_d = (vtype_sew == vdec_pkg::SEW8) ? vdec_pkg::SEW16 : vdec_pkg::SEW32;
    end else if (narrow) begin
      eew_d = (vtype_sew == vdec_pkg::SEW32) ? vdec_pkg::SEW16 : vdec_pkg::SEW8;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ctrl.legal   <= 1'b0;
      ctrl.vs2_src <= vdec_pkg::VS2_NORMAL;
      ctrl.vd_src  <= vdec_pkg::VD_NORMAL;
      ctrl.vm      <= 1'b1;
      ctrl.eew     <= vdec_pkg::SEW8;
    end else if (load) begin
      ctrl.legal   <= legal_d;
      ctrl.vs2_src <= vs2_src_d;
      ctrl.vd_src  <= vd_src_d;
      ctrl.vm      <= instr[25];
      ctrl.eew     <= eew_d;
    end
  end

  // vs1, rs1 and imm5 share the same instruction bits
  always_ff @(posedge CLK) begin
    if (load) begin
      ctrl.vd      <= instr[11:7];
      ctrl.vs1     <= instr[19:15];
      ctrl.vs2     <= instr[24:20];
      ctrl.imm5    <= instr[19:15];
      ctrl.rs1_val <= xs1;
    end
  end

endmodule

// File: design/vdec_lane_gen.sv
module vdec_lane_gen #(
  parameter int VLMAX = 32
) (
  input  logic [VLMAX-1:0] v0_mask,
  vdec_ctrl_if.user        ctrl,
  vdec_elem_if.cnt         elem,
  vdec_uop_if.src          uop
);

  vdec_pkg::offset_t idx;
  vdec_pkg::offset_t idx1;
  vdec_pkg::offset_t rs1_off;
  vdec_pkg::offset_t uimm;
  logic [VLMAX-1:0] mask_sh0;
  logic [VLMAX-1:0] mask_sh1;

  assign idx     = elem.offset;
  assign idx1    = elem.offset + 8'd1;
  assign rs1_off = ctrl.rs1_val[vdec_pkg::OFFSET_W-1:0];
  assign uimm    = vdec_pkg::offset_t'(ctrl.imm5);

  always_comb begin
    case (ctrl.vs2_src)
      vdec_pkg::VS2_IDX_PLUS_RS1: begin
        uop.vs2_offset0 = idx + rs1_off;
        uop.vs2_offset1 = idx1 + rs1_off;
      end
      vdec_pkg::VS2_IDX_PLUS_UIMM: begin
        uop.vs2_offset0 = idx + uimm;
        uop.vs2_offset1 = idx1 + uimm;
      end
      vdec_pkg::VS2_IDX_PLUS_1: begin
        uop.vs2_offset0 = idx1;
        uop.vs2_offset1 = idx + 8'd2;
      end
      // gather of one element into every lane
      vdec_pkg::VS2_RS1: begin
        uop.vs2_offset0 = rs1_off;
        uop.vs2_offset1 = rs1_off;
      end
      vdec_pkg::VS2_UIMM: begin
        uop.vs2_offset0 = uimm;
        uop.vs2_offset1 = uimm;
      end
      default: begin
        uop.vs2_offset0 = idx;
        uop.vs2_offset1 = idx1;
      end
    endcase
  end

  always_comb begin
    case (ctrl.vd_src)
      vdec_pkg::VD_IDX_PLUS_RS1: begin
        uop.woffset0 = idx + rs1_off;
        uop.woffset1 = idx1 + rs1_off;
      end
      vdec_pkg::VD_IDX_PLUS_UIMM: begin
        uop.woffset0 = idx + uimm;
        uop.woffset1 = idx1 + uimm;
      end
      vdec_pkg::VD_IDX_PLUS_1: begin
        uop.woffset0 = idx1;
        uop.woffset1 = idx + 8'd2;
      end
      default: begin
        uop.woffset0 = idx;
        uop.woffset1 = idx1;
      end
    endcase
  end

  // v0 bit of each lane, zero past the end of the mask
  assign mask_sh0 = v0_mask >> idx;
  assign mask_sh1 = v0_mask >> idx1;

  assign uop.wen0 = ctrl.vm || mask_sh0[0];
  assign uop.wen1 = elem.lane1_active && (ctrl.vm || mask_sh1[0]);

  assign uop.vd   = ctrl.vd;
  assign uop.vs1  = ctrl.vs1;
  assign uop.vs2  = ctrl.vs2;
  assign uop.eew  = ctrl.eew;
  assign uop.last = elem.last;

endmodule

// File: design/vdec_pkg.sv
package vdec_pkg;

  localparam int OFFSET_W = 8;

  typedef logic [31:0] instr_t;
  typedef logic [31:0] xlen_t;
  typedef logic [4:0] vreg_t;
  // element offsets wrap modulo 256
  typedef logic [OFFSET_W-1:0] offset_t;
  typedef logic [4:0] imm5_t;
  typedef logic [5:0] funct6_t;
  typedef logic [2:0] funct3_t;

  typedef enum logic [1:0] {SEW8 = 2'b00, SEW16 = 2'b01, SEW32 = 2'b10} sew_t;

  // where the vs2 element offsets of a micro-op come from
  typedef enum logic [2:0] {
    VS2_NORMAL,
    VS2_IDX_PLUS_RS1,
    VS2_IDX_PLUS_UIMM,
    VS2_IDX_PLUS_1,
    VS2_RS1,
    VS2_UIMM
  } vs2_src_t;

  typedef enum logic [1:0] {
    VD_NORMAL,
    VD_IDX_PLUS_RS1,
    VD_IDX_PLUS_UIMM,
    VD_IDX_PLUS_1
  } vd_src_t;

  typedef enum logic [1:0] {IDLE, ISSUE} seq_state_t;

  localparam funct6_t F6_VADD       = 6'b000000;
  localparam funct6_t F6_VSLIDEUP   = 6'b001110;
  localparam funct6_t F6_VSLIDEDOWN = 6'b001111;
  localparam funct6_t F6_VRGATHER   = 6'b001100;
  localparam funct6_t F6_VWADDU     = 6'b110000;
  localparam funct6_t F6_VNSRL      = 6'b101100;

  localparam funct3_t OPIVV = 3'b000;
  localparam funct3_t OPIVI = 3'b011;
  localparam funct3_t OPIVX = 3'b100;
  localparam funct3_t OPMVV = 3'b010;
  localparam funct3_t OPMVX = 3'b110;

endpackage

// File: design/vdec_seq_fsm.sv
module vdec_seq_fsm (
  input  logic       CLK,
  input  logic       nRST,
  input  logic       flush,
  input  logic       instr_valid,
  output logic       instr_ready,
  output logic       load,
  output logic       illegal,
  vdec_ctrl_if.user  ctrl,
  vdec_elem_if.seq   elem,
  vdec_uop_if.src    uop
);

  vdec_pkg::seq_state_t state;
  // an instruction was accepted last cycle and its decode is now visible
  logic pending;
  logic accept;
  logic xfer;

  // an illegal instruction frees the input in its check cycle
  assign instr_ready = (state == vdec_pkg::IDLE) && (!pending || !ctrl.legal);
  assign accept      = instr_valid && instr_ready;
  assign load        = accept;
  assign illegal     = pending && !ctrl.legal;

  assign uop.valid    = (state == vdec_pkg::ISSUE);
  assign xfer         = uop.valid && uop.ready;
  assign elem.start   = accept;
  assign elem.advance = xfer;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state   <= vdec_pkg::IDLE;
      pending <= 1'b0;
    end else if (flush) begin
      state   <= vdec_pkg::IDLE;
      pending <= accept;
    end else begin
      case (state)
        vdec_pkg::IDLE: begin
          pending <= accept;
          if (pending && ctrl.legal && !elem.empty) begin
            state <= vdec_pkg::ISSUE;
          end
        end
        vdec_pkg::ISSUE: begin
          if (xfer && elem.last) begin
            state <= vdec_pkg::IDLE;
          end
        end
        default: state <= vdec_pkg::IDLE;
      endcase
    end
  end

endmodule

// File: design/vdec_top.sv
module vdec_top #(
  parameter int VLMAX = 32
) (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic                       flush,
  input  logic                       instr_valid,
  output logic                       instr_ready,
  input  vdec_pkg::instr_t           instr,
  input  vdec_pkg::xlen_t            xs1,
  input  logic [$clog2(VLMAX+1)-1:0] vl,
  input  logic [$clog2(VLMAX+1)-1:0] vstart,
  input  vdec_pkg::sew_t             vtype_sew,
  input  logic [VLMAX-1:0]           v0_mask,
  output logic                       illegal,
  output logic                       uop_valid,
  input  logic                       uop_ready,
  output vdec_pkg::vreg_t            uop_vd,
  output vdec_pkg::vreg_t            uop_vs1,
  output vdec_pkg::vreg_t            uop_vs2,
  output vdec_pkg::offset_t          uop_woffset0,
  output vdec_pkg::offset_t          uop_woffset1,
  output vdec_pkg::offset_t          uop_vs2_offset0,
  output vdec_pkg::offset_t          uop_vs2_offset1,
  output logic                       uop_wen0,
  output logic                       uop_wen1,
  output vdec_pkg::sew_t             uop_eew,
  output logic                       uop_last
);

  logic load;

  vdec_ctrl_if ctrl_if ();
  vdec_elem_if elem_if ();
  vdec_uop_if  uop_if ();

  vdec_instr_decoder decoder_i (
    .CLK(CLK), .nRST(nRST), .load(load), .instr(instr), .xs1(xs1),
    .vtype_sew(vtype_sew), .ctrl(ctrl_if.dec)
  );

  vdec_seq_fsm fsm_i (
    .CLK(CLK), .nRST(nRST), .flush(flush), .instr_valid(instr_valid),
    .instr_ready(instr_ready), .load(load), .illegal(illegal),
    .ctrl(ctrl_if.user), .elem(elem_if.seq), .uop(uop_if.src)
  );

  vdec_element_counter #(.VLMAX(VLMAX)) counter_i (
    .CLK(CLK), .nRST(nRST), .vl(vl), .vstart(vstart), .elem(elem_if.cnt)
  );

  // payload side of the micro-op, valid comes from the FSM
  vdec_lane_gen #(.VLMAX(VLMAX)) lane_gen_i (
    .v0_mask(v0_mask), .ctrl(ctrl_if.user), .elem(elem_if.cnt), .uop(uop_if.src)
  );

  vdec_uop_reg uop_reg_i (
    .CLK(CLK), .nRST(nRST), .flush(flush), .uop(uop_if.dst), .uop_ready(uop_ready),
    .uop_valid(uop_valid), .uop_vd(uop_vd), .uop_vs1(uop_vs1), .uop_vs2(uop_vs2),
    .uop_woffset0(uop_woffset0), .uop_woffset1(uop_woffset1),
    .uop_vs2_offset0(uop_vs2_offset0), .uop_vs2_offset1(uop_vs2_offset1),
    .uop_wen0(uop_wen0), .uop_wen1(uop_wen1), .uop_eew(uop_eew), .uop_last(uop_last)
  );

endmodule

// File: design/vdec_uop_if.sv
interface vdec_uop_if;
  logic valid;
  logic ready;
  vdec_pkg::vreg_t vd;
  vdec_pkg::vreg_t vs1;
  vdec_pkg::vreg_t vs2;
  vdec_pkg::offset_t woffset0;
  vdec_pkg::offset_t woffset1;
  vdec_pkg::offset_t vs2_offset0;
  vdec_pkg::offset_t vs2_offset1;
  logic wen0;
  logic wen1;
  vdec_pkg::sew_t eew;
  logic last;

  modport src (
    output valid, vd, vs1, vs2, woffset0, woffset1, vs2_offset0, vs2_offset1,
    output wen0, wen1, eew, last,
    input ready
  );

  modport dst (
    input valid, vd, vs1, vs2, woffset0, woffset1, vs2_offset0, vs2_offset1,
    input wen0, wen1, eew, last,
    output ready
  );
endinterface

// File: design/vdec_uop_reg.sv
module vdec_uop_reg (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              flush,
  vdec_uop_if.dst           uop,
  input  logic              uop_ready,
  output logic              uop_valid,
  output vdec_pkg::vreg_t   uop_vd,
  output vdec_pkg::vreg_t   uop_vs1,
  output vdec_pkg::vreg_t   uop_vs2,
  output vdec_pkg::offset_t uop_woffset0,
  output vdec_pkg::offset_t uop_woffset1,
  output vdec_pkg::offset_t uop_vs2_offset0,
  output vdec_pkg::offset_t uop_vs2_offset1,
  output logic              uop_wen0,
  output logic              uop_wen1,
  output vdec_pkg::sew_t    uop_eew,
  output logic              uop_last
);

  logic xfer;

  // free when empty or when the held entry leaves this cycle
  assign uop.ready = !uop_valid || uop_ready;
  assign xfer      = uop.valid && uop.ready;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      uop_valid <= 1'b0;
    end else if (flush) begin
      uop_valid <= 1'b0;
    end else if (xfer) begin
      uop_valid <= 1'b1;
    end else if (uop_ready) begin
      uop_valid <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (xfer) begin
      uop_vd          <= uop.vd;
      uop_vs1         <= uop.vs1;
      uop_vs2         <= uop.vs2;
      uop_woffset0    <= uop.woffset0;
      uop_woffset1    <= uop.woffset1;
      uop_vs2_offset0 <= uop.vs2_offset0;
      uop_vs2_offset1 <= uop.vs2_offset1;
      uop_wen0        <= uop.wen0;
      uop_wen1        <= uop.wen1;
      uop_eew         <= uop.eew;
      uop_last        <= uop.last;
    end
  end

endmodule

// File: files.f
design/vdec_pkg.sv
design/vdec_ctrl_if.sv
design/vdec_elem_if.sv
design/vdec_uop_if.sv
design/vdec_instr_decoder.sv
design/vdec_seq_fsm.sv
design/vdec_element_counter.sv
design/vdec_lane_gen.sv
design/vdec_uop_reg.sv
design/vdec_top.sv
verification/vdec_tb.sv

// File: verification/vdec_tb.sv
module vdec_tb;

  localparam int VLMAX     = 32;
  localparam int MAX_INSTR = 64;
  localparam int MAX_UOP   = 256;

  logic CLK;
  logic nRST;
  logic flush;
  logic instr_valid;
  logic instr_ready;
  vdec_pkg::instr_t instr;
  vdec_pkg::xlen_t xs1;
  logic [$clog2(VLMAX+1)-1:0] vl;
  logic [$clog2(VLMAX+1)-1:0] vstart;
  vdec_pkg::sew_t vtype_sew;
  logic [VLMAX-1:0] v0_mask;
  logic illegal;
  logic uop_valid;
  logic uop_ready;
  vdec_pkg::vreg_t uop_vd;
  vdec_pkg::vreg_t uop_vs1;
  vdec_pkg::vreg_t uop_vs2;
  vdec_pkg::offset_t uop_woffset0;
  vdec_pkg::offset_t uop_woffset1;
  vdec_pkg::offset_t uop_vs2_offset0;
  vdec_pkg::offset_t uop_vs2_offset1;
  logic uop_wen0;
  logic uop_wen1;
  vdec_pkg::sew_t uop_eew;
  logic uop_last;

  // instructions from the vector file
  vdec_pkg::instr_t in_instr [MAX_INSTR];
  vdec_pkg::xlen_t in_xs1 [MAX_INSTR];
  logic [$clog2(VLMAX+1)-1:0] in_vl [MAX_INSTR];
  logic [$clog2(VLMAX+1)-1:0] in_vstart [MAX_INSTR];
  vdec_pkg::sew_t in_sew [MAX_INSTR];
  logic [VLMAX-1:0] in_v0 [MAX_INSTR];
  int in_flush [MAX_INSTR];
  int in_first [MAX_INSTR];
  int in_count [MAX_INSTR];
  logic in_illegal [MAX_INSTR];

  // expected micro-ops in issue order
  vdec_pkg::vreg_t ex_vd [MAX_UOP];
  vdec_pkg::vreg_t ex_vs1 [MAX_UOP];
  vdec_pkg::vreg_t ex_vs2 [MAX_UOP];
  vdec_pkg::offset_t ex_wo0 [MAX_UOP];
  vdec_pkg::offset_t ex_wo1 [MAX_UOP];
  vdec_pkg::offset_t ex_so0 [MAX_UOP];
  vdec_pkg::offset_t ex_so1 [MAX_UOP];
  logic ex_wen0 [MAX_UOP];
  logic ex_wen1 [MAX_UOP];
  vdec_pkg::sew_t ex_eew [MAX_UOP];
  logic ex_last [MAX_UOP];

  int n_instr = 0;
  int n_uop = 0;
  int n_lines = 0;
  int limit = 0;
  int cycles = 0;
  int value_errors = 0;
  int other_errors = 0;
  int seed = 32'hdefb;

  vdec_top #(.VLMAX(VLMAX)) vdec_top_i (
    .CLK(CLK), .nRST(nRST), .flush(flush), .instr_valid(instr_valid),
    .instr_ready(instr_ready), .instr(instr), .xs1(xs1), .vl(vl), .vstart(vstart),
    .vtype_sew(vtype_sew), .v0_mask(v0_mask), .illegal(illegal),
    .uop_valid(uop_valid), .uop_ready(uop_ready), .uop_vd(uop_vd), .uop_vs1(uop_vs1),
    .uop_vs2(uop_vs2), .uop_woffset0(uop_woffset0), .uop_woffset1(uop_woffset1),
    .uop_vs2_offset0(uop_vs2_offset0), .uop_vs2_offset1(uop_vs2_offset1),
    .uop_wen0(uop_wen0), .uop_wen1(uop_wen1), .uop_eew(uop_eew), .uop_last(uop_last)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: no progress within %0d cycles", limit);
      $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task read_vectors;
    int fd;
    int cnt;
    string line;
    logic [31:0] f [11];
    begin
      fd = $fopen("verification/vdec_vectors.txt", "r");
      if (fd == 0) begin
        $display("cannot open the vector file verification/vdec_vectors.txt");
        other_errors++;
      end else begin
        while (!$feof(fd)) begin
          line = "";
          cnt = $fgets(line, fd);
          if (cnt > 0 && line.len() > 0) begin
            n_lines++;
            if (line.getc(0) == "I") begin
              cnt = $sscanf(line, "I %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
              in_instr[n_instr]   = f[0];
              in_xs1[n_instr]     = f[1];
              in_vl[n_instr]      = f[2][$clog2(VLMAX+1)-1:0];
              in_vstart[n_instr]  = f[3][$clog2(VLMAX+1)-1:0];
              in_sew[n_instr]     = vdec_pkg::sew_t'(f[4][1:0]);
              in_v0[n_instr]      = f[5][VLMAX-1:0];
              // the flush count is optional
              in_flush[n_instr]   = (cnt > 6) ? int'(f[6]) : 0;
              in_first[n_instr]   = n_uop;
              in_count[n_instr]   = 0;
              in_illegal[n_instr] = 1'b0;
              n_instr++;
            end else if (line.getc(0) == "U" && n_instr > 0) begin
              cnt = $sscanf(line, "U %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                            f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
              ex_vd[n_uop]   = f[0][4:0];
              ex_vs1[n_uop]  = f[1][4:0];
              ex_vs2[n_uop]  = f[2][4:0];
              ex_wo0[n_uop]  = f[3][7:0];
              ex_wo1[n_uop]  = f[4][7:0];
              ex_so0[n_uop]  = f[5][7:0];
              ex_so1[n_uop]  = f[6][7:0];
              ex_wen0[n_uop] = f[7][0];
              ex_wen1[n_uop] = f[8][0];
              ex_eew[n_uop]  = vdec_pkg::sew_t'(f[9][1:0]);
              ex_last[n_uop] = f[10][0];
              in_count[n_instr-1]++;
              n_uop++;
            end else if (line.getc(0) == "X" && n_instr > 0) begin
              in_illegal[n_instr-1] = 1'b1;
            end
          end
        end
        $fclose(fd);
      end
    end
  endtask

  task drive_random_ready;
    begin
      uop_ready <= ($random(seed) & 3) != 0;
    end
  endtask

  task check_illegal(input logic exp);
    begin
      if (illegal !== exp) begin
        value_errors++;
        $display("FAIL %0t: illegal is %b, expected %b", $time, illegal, exp);
      end
    end
  endtask

  task check_ready(input logic exp);
    begin
      if (instr_ready !== exp) begin
        value_errors++;
        $display("FAIL %0t: instr_ready is %b, expected %b", $time, instr_ready, exp);
      end
    end
  endtask

  task check_uop(input int idx, input vdec_pkg::vreg_t vd, input vdec_pkg::vreg_t vs1,
                 input vdec_pkg::vreg_t vs2, input vdec_pkg::offset_t wo0,
                 input vdec_pkg::offset_t wo1, input vdec_pkg::offset_t so0,
                 input vdec_pkg::offset_t so1, input logic wen0, input logic wen1,
                 input vdec_pkg::sew_t eew, input logic last);
    begin
      if (uop_vd !== vd || uop_vs1 !== vs1 || uop_vs2 !== vs2 ||
          uop_woffset0 !== wo0 || uop_woffset1 !== wo1 ||
          uop_vs2_offset0 !== so0 || uop_vs2_offset1 !== so1 ||
          uop_wen0 !== wen0 || uop_wen1 !== wen1 || uop_eew !== eew || uop_last !== last) begin
        value_errors++;
        $display("FAIL %0t: micro-op %0d (vd vs1 vs2 woff vs2off wen eew last) differs",
                 $time, idx);
        $display("  got      %h %h %h  %h %h  %h %h  %b %b  %0d %b", uop_vd, uop_vs1,
                 uop_vs2, uop_woffset0, uop_woffset1, uop_vs2_offset0, uop_vs2_offset1,
                 uop_wen0, uop_wen1, uop_eew, uop_last);
        $display("  expected %h %h %h  %h %h  %h %h  %b %b  %0d %b", vd, vs1, vs2,
                 wo0, wo1, so0, so1, wen0, wen1, eew, last);
      end
    end
  endtask

  // one instruction from handshake to the quiet cycles after it
  task run_instr(input int n);
    int k;
    int j;
    logic accepted;
    logic extra;
    begin
      instr       <= in_instr[n];
      xs1         <= in_xs1[n];
      vl          <= in_vl[n];
      vstart      <= in_vstart[n];
      vtype_sew   <= in_sew[n];
      v0_mask     <= in_v0[n];
      instr_valid <= 1'b1;
      accepted = 1'b0;
      while (!accepted) begin
        @(posedge CLK);
        accepted = instr_valid && instr_ready;
        drive_random_ready();
      end
      instr_valid <= 1'b0;
      if (in_illegal[n]) begin
        @(posedge CLK);
        check_illegal(1'b1);
        // the input is free again while illegal is reported
        check_ready(1'b1);
        drive_random_ready();
      end else begin
        k = 0;
        while (k < in_count[n]) begin
          @(posedge CLK);
          check_illegal(1'b0);
          // the last micro-op cannot have reached the output register yet
          if (k + 1 < in_count[n]) begin
            check_ready(1'b0);
          end
          if (uop_valid && uop_ready) begin
            j = in_first[n] + k;
            check_uop(j, ex_vd[j], ex_vs1[j], ex_vs2[j], ex_wo0[j], ex_wo1[j],
                      ex_so0[j], ex_so1[j], ex_wen0[j], ex_wen1[j], ex_eew[j], ex_last[j]);
            k++;
          end
          drive_random_ready();
        end
        // drop the rest of the instruction while the output is stalled
        if (in_flush[n] != 0) begin
          flush     <= 1'b1;
          uop_ready <= 1'b0;
          @(posedge CLK);
          flush <= 1'b0;
        end
      end
      extra = 1'b0;
      repeat (3) begin
        @(posedge CLK);
        check_illegal(1'b0);
        if (uop_valid && !extra) begin
          other_errors++;
          extra = 1'b1;
          $display("instruction %0d produced a micro-op that was not expected (time %0t)",
                   n, $time);
        end
        drive_random_ready();
      end
    end
  endtask

  initial begin
    nRST        <= 1'b0;
    flush       <= 1'b0;
    instr_valid <= 1'b0;
    instr       <= '0;
    xs1         <= '0;
    vl          <= '0;
    vstart      <= '0;
    vtype_sew   <= vdec_pkg::SEW8;
    v0_mask     <= '0;
    uop_ready   <= 1'b0;
    read_vectors();
    limit = 8 * n_lines + 100;
    repeat (8) @(posedge CLK);
    nRST <= 1'b1;
    for (int i = 0; i < n_instr; i++) begin
      run_instr(i);
    end
    $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: verification/vdec_vectors.txt
# I instr xs1 vl vstart sew v0_mask [flush_after]    (hex, flush_after optional)
# U vd vs1 vs2 woff0 woff1 vs2off0 vs2off1 wen0 wen1 eew last, or X for illegal
I 023100d7 00000000 07 00 0 00000000
U 01 02 03 00 01 00 01 1 1 0 0
U 01 02 03 02 03 02 03 1 1 0 0
U 01 02 03 04 05 04 05 1 1 0 0
U 01 02 03 06 07 06 07 1 0 0 1
I 3a3140d7 00000105 01 00 0 00000000
U 01 02 03 05 06 00 01 1 0 0 1
I 3a34b0d7 00000000 01 00 0 00000000
U 01 09 03 09 0a 00 01 1 0 0 1
I 3a3160d7 00000000 01 00 0 00000000
U 01 02 03 01 02 00 01 1 0 0 1
I 3e3140d7 00000105 01 00 0 00000000
U 01 02 03 00 01 05 06 1 0 0 1
I 3e34b0d7 00000000 01 00 0 00000000
U 01 09 03 00 01 09 0a 1 0 0 1
I 3e3160d7 00000000 01 00 0 00000000
U 01 02 03 00 01 01 02 1 0 0 1
I 323140d7 00000107 02 00 0 00000000
U 01 02 03 00 01 07 07 1 1 0 1
I 323fb0d7 00000000 02 00 0 00000000
U 01 1f 03 00 01 1f 1f 1 1 0 1
I 003100d7 00000000 08 03 1 00000068
U 01 02 03 03 04 03 04 1 0 1 0
U 01 02 03 05 06 05 06 1 1 1 0
U 01 02 03 07 08 07 08 0 0 1 1
I 023100d7 00000000 05 05 0 ffffffff
I 023120d7 00000000 04 00 0 00000000
X
I 0234b0d7 00000000 10 00 2 00000000 2
U 01 09 03 00 01 00 01 1 1 2 0
U 01 09 03 02 03 02 03 1 1 2 0
I c23120d7 00000000 01 00 0 00000000
U 01 02 03 00 01 00 01 1 0 1 1
I c23120d7 00000000 01 00 1 00000000
U 01 02 03 00 01 00 01 1 0 2 1
I c23120d7 00000000 01 00 2 00000000
U 01 02 03 00 01 00 01 1 0 2 1
I b23100d7 00000000 01 00 2 00000000
U 01 02 03 00 01 00 01 1 0 1 1
I b23100d7 00000000 01 00 1 00000000
U 01 02 03 00 01 00 01 1 0 0 1
I b23100d7 00000000 01 00 0 00000000
U 01 02 03 00 01 00 01 1 0 0 1
I fe3100d7 00000000 03 00 0 00000000
X
